// File: rtl/fpslice_pkg.sv
// ------------------------------
// FP slice package
// Widths, operand types, opcodes and canonical NaNs
// ------------------------------

package fpslice_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned WIDTH      = 32;
  localparam int unsigned NUM_LANES  = 2;
  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;
  localparam int unsigned TAG_WIDTH  = 4;
  localparam int unsigned STATUS_NV  = 4;   // Invalid flag position in status_t

  // ------------------------------
  // Types
  // ------------------------------
  typedef logic [WIDTH-1:0]      word_t;
  typedef logic [FP16_WIDTH-1:0] half_t;
  typedef logic [TAG_WIDTH-1:0]  tag_t;
  typedef logic [NUM_LANES-1:0]  lane_mask_t;

  // Flags: invalid, div-by-zero, overflow, underflow, inexact
  typedef logic [4:0] status_t;

  typedef enum logic {
    FMT_FP32,
    FMT_FP16
  } fp_format_e;

  typedef enum logic [2:0] {
    OP_SGNJ,     // Copy sign of b
    OP_SGNJN,    // Negated sign of b
    OP_SGNJX,    // Xor of both signs
    OP_MIN,
    OP_MAX
  } noncomp_op_e;

  // Canonical quiet NaNs
  localparam word_t QNAN_FP32 = 32'h7FC0_0000;
  localparam half_t QNAN_FP16 = 16'h7E00;

endpackage

// File: rtl/fpslice_lane_if.sv
// ------------------------------
// Lane operand bus
// Unpacked operands and control into the lane stage
// ------------------------------
`timescale 1ns/1ps

interface fpslice_lane_if;
  logic                     valid;
  logic                     ready;
  fpslice_pkg::word_t       a0, b0;   // Lane 0 holds FP32 or FP16
  fpslice_pkg::half_t       a1, b1;   // Lane 1 is FP16 only
  fpslice_pkg::noncomp_op_e op;
  fpslice_pkg::fp_format_e  fmt;
  logic                     vectorial;
  fpslice_pkg::tag_t        tag;
  fpslice_pkg::lane_mask_t  mask;

  modport src (output valid, a0, b0, a1, b1, op, fmt, vectorial, tag, mask,
               input  ready);
  modport dst (input  valid, a0, b0, a1, b1, op, fmt, vectorial, tag, mask,
               output ready);
endinterface

// File: rtl/fpslice_result_if.sv
// ------------------------------
// Lane result bus
// Lane results and flags into the pack stage
// ------------------------------
`timescale 1ns/1ps

interface fpslice_result_if;
  logic                    valid;
  logic                    ready;
  fpslice_pkg::word_t      res0;
  fpslice_pkg::half_t      res1;
  fpslice_pkg::status_t    status0;
  fpslice_pkg::status_t    status1;
  fpslice_pkg::fp_format_e fmt;
  logic                    vectorial;
  fpslice_pkg::tag_t       tag;
  fpslice_pkg::lane_mask_t mask;

  modport src (output valid, res0, res1, status0, status1, fmt, vectorial, tag, mask,
               input  ready);
  modport dst (input  valid, res0, res1, status0, status1, fmt, vectorial, tag, mask,
               output ready);
endinterface

// File: rtl/fpslice_noncomp_lane.sv
// ------------------------------
// Non-computational lane
// Sign injection and IEEE min/max
// ------------------------------
`timescale 1ns/1ps

module fpslice_noncomp_lane #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic [LaneWidth-1:0]     a_i,
  input  logic [LaneWidth-1:0]     b_i,
  input  fpslice_pkg::noncomp_op_e op_i,
  input  fpslice_pkg::fp_format_e  fmt_i,
  output logic [LaneWidth-1:0]     result_o,
  output fpslice_pkg::status_t     status_o
);

  fpslice_pkg::word_t [1:0] opnd;       // Index 0 is a, 1 is b
  logic [1:0]               sgn, nan, snan;
  logic [1:0][30:0]         mag;
  logic                     a_lt_b, pick_a;
  fpslice_pkg::word_t       res_ext;

  // Rebuild a value from sign and magnitude, FP16 comes out boxed
  function automatic fpslice_pkg::word_t pack_fp(input fpslice_pkg::fp_format_e fmt,
                                                 input logic sign, input logic [30:0] m);
    if (fmt == fpslice_pkg::FMT_FP16) begin
      return {{fpslice_pkg::FP16_WIDTH{1'b1}}, sign, m[14:0]};
    end
    return {sign, m};
  endfunction

  assign opnd[0] = fpslice_pkg::word_t'(a_i);
  assign opnd[1] = fpslice_pkg::word_t'(b_i);

  always_comb begin : decode
    for (int i = 0; i < 2; i++) begin
      if (fmt_i == fpslice_pkg::FMT_FP16) begin
        sgn[i]  = opnd[i][15];
        mag[i]  = {16'b0, opnd[i][14:0]};
        nan[i]  = (&opnd[i][14:10]) & (|opnd[i][9:0]);
        snan[i] = nan[i] & ~opnd[i][9];          // Quiet bit clear
      end else begin
        sgn[i]  = opnd[i][fpslice_pkg::FP32_WIDTH-1];
        mag[i]  = opnd[i][30:0];
        nan[i]  = (&opnd[i][30:23]) & (|opnd[i][22:0]);
        snan[i] = nan[i] & ~opnd[i][22];
      end
    end
  end

  // -0 sorts below +0 through the sign compare
  assign a_lt_b = (sgn[0] != sgn[1]) ? sgn[0]
                : (sgn[0] ? (mag[0] > mag[1]) : (mag[0] < mag[1]));
  assign pick_a = (op_i == fpslice_pkg::OP_MIN) ? a_lt_b : ~a_lt_b;

  always_comb begin : compute
    status_o = '0;
    case (op_i)
      fpslice_pkg::OP_SGNJ:  res_ext = pack_fp(fmt_i, sgn[1], mag[0]);
      fpslice_pkg::OP_SGNJN: res_ext = pack_fp(fmt_i, ~sgn[1], mag[0]);
      fpslice_pkg::OP_SGNJX: res_ext = pack_fp(fmt_i, sgn[0] ^ sgn[1], mag[0]);
      default: begin // Min and max
        status_o[fpslice_pkg::STATUS_NV] = |snan;
        if (&nan) begin
          res_ext = (fmt_i == fpslice_pkg::FMT_FP16)
                    ? {{fpslice_pkg::FP16_WIDTH{1'b1}}, fpslice_pkg::QNAN_FP16}
                    : fpslice_pkg::QNAN_FP32;
        end else if (nan[0] || (!nan[1] && !pick_a)) begin
          res_ext = pack_fp(fmt_i, sgn[1], mag[1]);
        end else begin
          res_ext = pack_fp(fmt_i, sgn[0], mag[0]);
        end
      end
    endcase
  end

  assign result_o = res_ext[LaneWidth-1:0];

endmodule

// File: rtl/fpslice_operand_unpack.sv
// ------------------------------
// Operand unpack stage
// Box check, lane slicing and input register
// ------------------------------
`timescale 1ns/1ps

module fpslice_operand_unpack (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  fpslice_pkg::word_t       operand_a_i,
  input  fpslice_pkg::word_t       operand_b_i,
  input  fpslice_pkg::noncomp_op_e op_i,
  input  fpslice_pkg::fp_format_e  fmt_i,
  input  logic                     vectorial_i,
  input  fpslice_pkg::tag_t        tag_i,
  input  fpslice_pkg::lane_mask_t  simd_mask_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  fpslice_lane_if.src              lane_o
);

  localparam fpslice_pkg::word_t BOXED_QNAN =
      {{fpslice_pkg::FP16_WIDTH{1'b1}}, fpslice_pkg::QNAN_FP16};

  logic               vectorial;
  logic               scalar_fp16;
  logic               load;
  logic               valid_q;
  fpslice_pkg::word_t a_lane0, b_lane0;

  assign vectorial   = vectorial_i & (fmt_i == fpslice_pkg::FMT_FP16); // FP32 has one lane
  assign scalar_fp16 = (fmt_i == fpslice_pkg::FMT_FP16) & ~vectorial;

  // Badly boxed scalar FP16 reads as canonical NaN
  assign a_lane0 = (scalar_fp16 && !(&operand_a_i[fpslice_pkg::WIDTH-1:fpslice_pkg::FP16_WIDTH]))
                   ? BOXED_QNAN : operand_a_i;
  assign b_lane0 = (scalar_fp16 && !(&operand_b_i[fpslice_pkg::WIDTH-1:fpslice_pkg::FP16_WIDTH]))
                   ? BOXED_QNAN : operand_b_i;

  assign in_ready_o   = ~valid_q | lane_o.ready;
  assign load         = in_valid_i & in_ready_o;
  assign lane_o.valid = valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (lane_o.ready) begin
      valid_q <= 1'b0;     // Item taken by the lanes
    end
  end

  // Payload register
  always_ff @(posedge clk_i) begin
    if (load) begin
      lane_o.a0        <= a_lane0;
      lane_o.b0        <= b_lane0;
      lane_o.a1        <= operand_a_i[fpslice_pkg::WIDTH-1:fpslice_pkg::FP16_WIDTH];
      lane_o.b1        <= operand_b_i[fpslice_pkg::WIDTH-1:fpslice_pkg::FP16_WIDTH];
      lane_o.op        <= op_i;
      lane_o.fmt       <= fmt_i;
      lane_o.vectorial <= vectorial;
      lane_o.tag       <= tag_i;
      lane_o.mask      <= simd_mask_i;
    end
  end

endmodule

// File: rtl/fpslice_lane_array.sv
// ------------------------------
// Lane stage
// Runs both lanes and registers their results
// ------------------------------
`timescale 1ns/1ps

module fpslice_lane_array (
  input  logic              clk_i,
  input  logic              rst_n_i,
  fpslice_lane_if.dst       lane_i,
  fpslice_result_if.src     res_o,
  output logic              busy_o
);

  fpslice_pkg::word_t   lane0_res;
  fpslice_pkg::half_t   lane1_res;
  fpslice_pkg::status_t lane0_status, lane1_status;
  logic                 valid_q;
  logic                 load;

  fpslice_noncomp_lane #(.LaneWidth(fpslice_pkg::FP32_WIDTH)) i_lane0 (
    .a_i      ( lane_i.a0    ),
    .b_i      ( lane_i.b0    ),
    .op_i     ( lane_i.op    ),
    .fmt_i    ( lane_i.fmt   ),
    .result_o ( lane0_res    ),
    .status_o ( lane0_status )
  );

  // Upper lane only ever sees FP16
  fpslice_noncomp_lane #(.LaneWidth(fpslice_pkg::FP16_WIDTH)) i_lane1 (
    .a_i      ( lane_i.a1             ),
    .b_i      ( lane_i.b1             ),
    .op_i     ( lane_i.op             ),
    .fmt_i    ( fpslice_pkg::FMT_FP16 ),
    .result_o ( lane1_res             ),
    .status_o ( lane1_status          )
  );

  assign lane_i.ready = ~valid_q | res_o.ready;
  assign load         = lane_i.valid & lane_i.ready;
  assign res_o.valid  = valid_q;
  assign busy_o       = lane_i.valid | valid_q;   // Item waiting or held here

  always_ff @(posedge clk_i) begin
    if (!rst_n_i)               valid_q <= 1'b0;
    else if (load)              valid_q <= 1'b1;
    else if (res_o.ready)       valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      res_o.res0      <= lane0_res;
      res_o.res1      <= lane1_res;
      res_o.status0   <= lane0_status;
      res_o.status1   <= lane_i.vectorial ? lane1_status : '0; // Idle lane raises nothing
      res_o.fmt       <= lane_i.fmt;
      res_o.vectorial <= lane_i.vectorial;
      res_o.tag       <= lane_i.tag;
      res_o.mask      <= lane_i.mask;
    end
  end

endmodule

// File: rtl/fpslice_result_pack.sv
// ------------------------------
// Result pack stage
// Format packing, FP16 boxing and flag collapse
// ------------------------------
`timescale 1ns/1ps

module fpslice_result_pack (
  fpslice_result_if.dst        res_i,
  input  logic                 lane_busy_i,
  output fpslice_pkg::word_t   result_o,
  output fpslice_pkg::status_t status_o,
  output fpslice_pkg::tag_t    tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  localparam int unsigned SW = $bits(fpslice_pkg::status_t);

  always_comb begin : pack
    if (res_i.fmt == fpslice_pkg::FMT_FP32) begin
      result_o = res_i.res0;
    end else if (res_i.vectorial) begin
      result_o = {res_i.res1, res_i.res0[fpslice_pkg::FP16_WIDTH-1:0]};
    end else begin
      // Scalar FP16 is NaN-boxed
      result_o = {{fpslice_pkg::FP16_WIDTH{1'b1}}, res_i.res0[fpslice_pkg::FP16_WIDTH-1:0]};
    end
  end

  // Masked lanes do not report flags
  assign status_o = (res_i.status0 & {SW{res_i.mask[0]}})
                  | (res_i.status1 & {SW{res_i.mask[1]}});

  assign tag_o       = res_i.tag;
  assign out_valid_o = res_i.valid;
  assign res_i.ready = out_ready_i;
  assign busy_o      = lane_busy_i | res_i.valid;

endmodule

// File: rtl/fpslice_top.sv
// ------------------------------
// FP slice top
// Unpack, lanes and pack in a 2-deep pipeline
// ------------------------------
`timescale 1ns/1ps

module fpslice_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Input side
  input  fpslice_pkg::word_t       operand_a_i,
  input  fpslice_pkg::word_t       operand_b_i,
  input  fpslice_pkg::noncomp_op_e op_i,
  input  fpslice_pkg::fp_format_e  fmt_i,
  input  logic                     vectorial_i,
  input  fpslice_pkg::tag_t        tag_i,
  input  fpslice_pkg::lane_mask_t  simd_mask_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  // Output side
  output fpslice_pkg::word_t       result_o,
  output fpslice_pkg::status_t     status_o,
  output fpslice_pkg::tag_t        tag_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic                     busy_o
);

  fpslice_lane_if   lane_bus ();
  fpslice_result_if res_bus ();
  logic             lane_busy;

  fpslice_operand_unpack i_unpack (
    .clk_i, .rst_n_i,
    .operand_a_i, .operand_b_i, .op_i, .fmt_i, .vectorial_i, .tag_i, .simd_mask_i,
    .in_valid_i, .in_ready_o,
    .lane_o ( lane_bus.src )
  );

  fpslice_lane_array i_lanes (
    .clk_i, .rst_n_i,
    .lane_i ( lane_bus.dst ),
    .res_o  ( res_bus.src  ),
    .busy_o ( lane_busy    )
  );

  fpslice_result_pack i_pack (
    .res_i       ( res_bus.dst ),
    .lane_busy_i ( lane_busy   ),
    .result_o, .status_o, .tag_o, .out_valid_o, .out_ready_i, .busy_o
  );

endmodule

// File: verif/fpslice_checker.sv
// ------------------------------
// FP slice checker
// Handshake assertions on the top-level output
// ------------------------------
`timescale 1ns/1ps

module fpslice_checker (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input fpslice_pkg::word_t   result_o,
  input fpslice_pkg::status_t status_o,
  input fpslice_pkg::tag_t    tag_o,
  input logic                 out_valid_o,
  input logic                 out_ready_i,
  input logic                 busy_o
);

  // Stalled output keeps its payload
  a_hold_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i |=> $stable(result_o) && $stable(status_o) && $stable(tag_o))
    else $error("Output payload changed while stalled");

  a_empty_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !out_valid_o)
    else $error("Output valid right after reset");

  a_busy_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o |-> busy_o)
    else $error("Busy low while a result is valid");

endmodule

bind fpslice_top fpslice_checker i_checker (
  .clk_i, .rst_n_i, .result_o, .status_o, .tag_o, .out_valid_o, .out_ready_i, .busy_o
);

// File: verif/tb_fpslice.sv
// ------------------------------
// FP slice testbench
// Directed tests against a lane reference model
// ------------------------------
`timescale 1ns/1ps

module tb_fpslice;

  localparam int unsigned MAX_CYCLES = 2000;

  logic clk_i, rst_n_i;
  fpslice_pkg::word_t       operand_a_i, operand_b_i, result_o;
  fpslice_pkg::noncomp_op_e op_i;
  fpslice_pkg::fp_format_e  fmt_i;
  fpslice_pkg::tag_t        tag_i, tag_o, tag_cnt;
  fpslice_pkg::lane_mask_t  simd_mask_i;
  fpslice_pkg::status_t     status_o;
  logic vectorial_i, in_valid_i, in_ready_o, out_valid_o, out_ready_i, busy_o;

  int unsigned          cycles = 0;
  logic [31:0]          lfsr_state, ready_bits;
  logic                 bp_mode;          // Random out_ready_i when set
  fpslice_pkg::word_t   exp_res_q[$];
  fpslice_pkg::status_t exp_stat_q[$];
  fpslice_pkg::tag_t    exp_tag_q[$];
  int unsigned          acc_q[$];         // Edge of input transfer

  fpslice_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [31:0] with_sign(input logic half, input logic s,
                                            input logic [30:0] m);
    return half ? {16'h0, s, m[14:0]} : {s, m};
  endfunction

  // Unsigned ordering key, negatives fall below all positives and -0 below +0
  function automatic logic [31:0] order_key(input logic s, input logic [30:0] m);
    return s ? {1'b0, ~m} : {1'b1, m};
  endfunction

  // Bit 32 is the invalid flag, low bits the lane value
  function automatic logic [32:0] ref_lane(input logic half, input logic [31:0] a,
                                           input logic [31:0] b,
                                           input fpslice_pkg::noncomp_op_e op);
    logic        sa, sb, na, nb, sna, snb, a_less;
    logic [30:0] ma, mb;
    logic [31:0] res;
    sa  = half ? a[15] : a[31];
    sb  = half ? b[15] : b[31];
    ma  = half ? {16'b0, a[14:0]} : a[30:0];
    mb  = half ? {16'b0, b[14:0]} : b[30:0];
    na  = half ? (a[14:10] == 5'h1F && a[9:0] != 0) : (a[30:23] == 8'hFF && a[22:0] != 0);
    nb  = half ? (b[14:10] == 5'h1F && b[9:0] != 0) : (b[30:23] == 8'hFF && b[22:0] != 0);
    sna = na & ~(half ? a[9] : a[22]);   // Quiet bit clear
    snb = nb & ~(half ? b[9] : b[22]);
    a_less = order_key(sa, ma) < order_key(sb, mb);
    case (op)
      fpslice_pkg::OP_SGNJ:  return {1'b0, with_sign(half, sb, ma)};
      fpslice_pkg::OP_SGNJN: return {1'b0, with_sign(half, ~sb, ma)};
      fpslice_pkg::OP_SGNJX: return {1'b0, with_sign(half, sa ^ sb, ma)};
      default: begin
        if (na && nb) res = half ? 32'h0000_7E00 : 32'h7FC0_0000;
        else if (na) res = b;
        else if (nb) res = a;
        else if ((op == fpslice_pkg::OP_MIN) == a_less) res = a;
        else res = b;
        return {sna | snb, res};
      end
    endcase
  endfunction

  task automatic predict(input logic [31:0] a, input logic [31:0] b,
                         input fpslice_pkg::noncomp_op_e op, input fpslice_pkg::fp_format_e fmt,
                         input logic vec, input logic [1:0] mask,
                         output logic [31:0] er, output logic [4:0] es);
    logic [32:0] r0, r1;
    logic [31:0] aa, bb;
    if (fmt == fpslice_pkg::FMT_FP32) begin
      r0 = ref_lane(1'b0, a, b, op);
      er = r0[31:0];
      es = {r0[32] & mask[0], 4'b0};
    end else if (!vec) begin
      aa = (a[31:16] == 16'hFFFF) ? a : 32'hFFFF_7E00;   // Bad box reads as NaN
      bb = (b[31:16] == 16'hFFFF) ? b : 32'hFFFF_7E00;
      r0 = ref_lane(1'b1, aa, bb, op);
      er = {16'hFFFF, r0[15:0]};
      es = {r0[32] & mask[0], 4'b0};
    end else begin
      r0 = ref_lane(1'b1, a, b, op);
      r1 = ref_lane(1'b1, {16'h0, a[31:16]}, {16'h0, b[31:16]}, op);
      er = {r1[15:0], r0[15:0]};
      es = {(r0[32] & mask[0]) | (r1[32] & mask[1]), 4'b0};
    end
  endtask

  // ------------------------------
  // Driver and output monitor
  // ------------------------------
  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_next(input logic [31:0] a, input logic [31:0] b,
                           input fpslice_pkg::noncomp_op_e op,
                           input fpslice_pkg::fp_format_e fmt,
                           input logic vec, input logic [1:0] mask);
    logic [31:0] er;
    logic [4:0]  es;
    logic        done;
    predict(a, b, op, fmt, vec, mask, er, es);
    operand_a_i = a;
    operand_b_i = b;
    op_i        = op;
    fmt_i       = fmt;
    vectorial_i = vec;
    tag_i       = tag_cnt;
    simd_mask_i = mask;
    in_valid_i  = 1'b1;
    done        = 1'b0;
    while (!done) begin
      #1;
      if (in_ready_o) begin
        exp_res_q.push_back(er);
        exp_stat_q.push_back(es);
        exp_tag_q.push_back(tag_cnt);
        acc_q.push_back(cycles + 1);
        done = 1'b1;
      end
      @(negedge clk_i);
    end
    check("busy_o", 32'(busy_o), 32'd1);   // Accepted item sits in the pipeline
    tag_cnt = tag_cnt + 1'b1;
  endtask

  task automatic minmax_pair(input logic [31:0] a, input logic [31:0] b,
                             input fpslice_pkg::fp_format_e fmt, input logic vec,
                             input logic [1:0] mask);
    send_next(a, b, fpslice_pkg::OP_MIN, fmt, vec, mask);
    send_next(a, b, fpslice_pkg::OP_MAX, fmt, vec, mask);
  endtask

  task automatic drain();
    in_valid_i = 1'b0;
    while (exp_res_q.size() != 0) @(negedge clk_i);
    check("busy_o", 32'(busy_o), 32'd0);
    check("out_valid_o", 32'(out_valid_o), 32'd0);
  endtask

  always @(negedge clk_i) begin
    if (bp_mode) begin
      rand_bits(1, ready_bits);
      out_ready_i = ready_bits[0];
    end else begin
      out_ready_i = 1'b1;
    end
    #1;
    if (out_valid_o && out_ready_i) begin
      if (exp_res_q.size() == 0) begin
        $display("Result with tag %0d arrived with no operation outstanding", tag_o);
        $display("SIMULATION FAILED");
        $fatal(1, "unexpected result");
      end else begin
        check("result_o[15:0]", 32'(result_o[15:0]), 32'(exp_res_q[0][15:0]));
        check("result_o[31:16]", 32'(result_o[31:16]), 32'(exp_res_q[0][31:16]));
        check("status_o", 32'(status_o), 32'(exp_stat_q[0]));
        check("tag_o", 32'(tag_o), 32'(exp_tag_q[0]));
        if (!bp_mode) check("latency", cycles + 1 - acc_q[0], 32'd2);
        void'(exp_res_q.pop_front());
        void'(exp_stat_q.pop_front());
        void'(exp_tag_q.pop_front());
        void'(acc_q.pop_front());
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic fp32_sign_inject();
    logic [31:0] a, b;
    for (int i = 0; i < 20; i++) begin
      rand_bits(32, a);
      rand_bits(32, b);
      send_next(a, b, fpslice_pkg::OP_SGNJ, fpslice_pkg::FMT_FP32, 1'b0, 2'b11);
      send_next(a, b, fpslice_pkg::OP_SGNJN, fpslice_pkg::FMT_FP32, 1'b0, 2'b11);
      send_next(a, b, fpslice_pkg::OP_SGNJX, fpslice_pkg::FMT_FP32, 1'b0, 2'b11);
    end
    drain();
  endtask

  task automatic fp32_min_max();
    minmax_pair(32'h3F80_0000, 32'h4000_0000, fpslice_pkg::FMT_FP32, 1'b0, 2'b01);
    minmax_pair(32'hC040_0000, 32'h3F00_0000, fpslice_pkg::FMT_FP32, 1'b0, 2'b01);
    minmax_pair(32'hC000_0000, 32'hC040_0000, fpslice_pkg::FMT_FP32, 1'b0, 2'b01);
    minmax_pair(32'h8000_0000, 32'h0000_0000, fpslice_pkg::FMT_FP32, 1'b0, 2'b01); // -0 vs +0
    minmax_pair(32'h0000_0000, 32'h8000_0000, fpslice_pkg::FMT_FP32, 1'b0, 2'b01);
    minmax_pair(32'h7FC0_0000, 32'h4040_0000, fpslice_pkg::FMT_FP32, 1'b0, 2'b01);
    minmax_pair(32'hC0A0_0000, 32'h7FC1_2345, fpslice_pkg::FMT_FP32, 1'b0, 2'b01);
    minmax_pair(32'h7FC0_0000, 32'hFFC0_0001, fpslice_pkg::FMT_FP32, 1'b0, 2'b01);
    minmax_pair(32'h7F80_0001, 32'h3F80_0000, fpslice_pkg::FMT_FP32, 1'b0, 2'b01); // Signalling
    minmax_pair(32'h7F80_0001, 32'h3F80_0000, fpslice_pkg::FMT_FP32, 1'b0, 2'b00);
    // Upper half of b reads as an FP16 sNaN, FP32 has no lane 1
    minmax_pair(32'hBF80_0000, 32'h7D00_0000, fpslice_pkg::FMT_FP32, 1'b1, 2'b10);
    drain();
  endtask

  task automatic fp16_scalar_ops();
    minmax_pair(32'hFFFF_3C00, 32'hFFFF_C000, fpslice_pkg::FMT_FP16, 1'b0, 2'b01);
    send_next(32'hFFFF_3C00, 32'hFFFF_C000, fpslice_pkg::OP_SGNJX,
              fpslice_pkg::FMT_FP16, 1'b0, 2'b01);
    send_next(32'hFFFF_BC00, 32'hFFFF_C000, fpslice_pkg::OP_SGNJN,
              fpslice_pkg::FMT_FP16, 1'b0, 2'b11);
    minmax_pair(32'h0000_3C00, 32'hFFFF_4000, fpslice_pkg::FMT_FP16, 1'b0, 2'b01); // Bad box a
    minmax_pair(32'hFFFF_4200, 32'h1234_5678, fpslice_pkg::FMT_FP16, 1'b0, 2'b01); // Bad box b
    drain();
  endtask

  task automatic fp16_vector_min();
    for (int m = 0; m < 4; m++) begin
      send_next(32'h7D00_3C00, 32'h4000_BC00, fpslice_pkg::OP_MIN,
                fpslice_pkg::FMT_FP16, 1'b1, 2'(m));
    end
    send_next(32'h3555_7C01, 32'h3400_0001, fpslice_pkg::OP_MIN,
              fpslice_pkg::FMT_FP16, 1'b1, 2'b10);        // Signalling NaN in lane 0
    drain();
  endtask

  task automatic backpressure_order();
    logic [31:0] a [10];
    logic [31:0] b [10];
    for (int i = 0; i < 10; i++) begin
      rand_bits(32, a[i]);
      rand_bits(32, b[i]);
    end
    tag_cnt = '0;
    @(posedge clk_i);
    bp_mode = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < 10; i++) begin
      send_next(a[i], b[i], fpslice_pkg::noncomp_op_e'(i % 5),
                fpslice_pkg::fp_format_e'(i % 2), (i % 2) == 1, 2'b11);
    end
    drain();
    bp_mode = 1'b0;
  endtask

  initial begin
    lfsr_state  = 32'h3569;
    bp_mode     = 1'b0;
    tag_cnt     = '0;
    rst_n_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = fpslice_pkg::OP_SGNJ;
    fmt_i       = fpslice_pkg::FMT_FP32;
    vectorial_i = 1'b0;
    tag_i       = '0;
    simd_mask_i = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check("out_valid_o", 32'(out_valid_o), 32'd0);
    check("busy_o", 32'(busy_o), 32'd0);
    check("in_ready_o", 32'(in_ready_o), 32'd1);
    @(negedge clk_i);
    fp32_sign_inject();
    fp32_min_max();
    fp16_scalar_ops();
    fp16_vector_min();
    backpressure_order();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: fpslice_top.f
rtl/fpslice_pkg.sv
rtl/fpslice_lane_if.sv
rtl/fpslice_result_if.sv
rtl/fpslice_noncomp_lane.sv
rtl/fpslice_operand_unpack.sv
rtl/fpslice_lane_array.sv
rtl/fpslice_result_pack.sv
rtl/fpslice_top.sv
verif/fpslice_checker.sv
verif/tb_fpslice.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fpslice -f fpslice_top.f -Mdir obj_dir

out=$(./obj_dir/Vtb_fpslice) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
